// File: source/rvCorePkg.sv
package rvCorePkg;

	parameter int xlen = 32;
	parameter int regAddrWidth = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	typedef enum logic [6:0] {
		opOp = 7'b0110011,
		opImm = 7'b0010011,
		opLui = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal = 7'b1101111
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		regAddr_t rs2;
		regAddr_t rs1;
		logic [2:0] funct3;
		regAddr_t rd;
		logic [6:0] opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		regAddr_t rs1;
		logic [2:0] funct3;
		regAddr_t rd;
		logic [6:0] opcode;
	} iType_t;

	// Same instruction word in two field layouts
	typedef union packed {
		rType_t r;
		iType_t i;
	} instruction_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		instruction_t instruction;
	} fetchItem_t;

	typedef struct packed {
		logic valid;
		regAddr_t rd;
		word_t result;
	} writebackItem_t;

	typedef enum logic [1:0] {
		regionSystem = 2'b00,
		regionRegisters = 2'b01
	} mgmtRegion_t;

	typedef struct packed {
		logic writeEnable;
		logic [3:0] byteSelect;
		logic [15:0] address;
		word_t writeData;
	} mgmtRequest_t;

endpackage

// File: source/instructionFetch.sv
`timescale 1ns/100ps

module instructionFetch #(
	parameter rvCorePkg::word_t resetPc = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic fetchAllowed,
	input logic redirect,
	input rvCorePkg::word_t redirectTarget,
	input logic pcWrite,
	input rvCorePkg::word_t pcWriteData,
	input rvCorePkg::word_t instrData,
	output rvCorePkg::word_t instrAddress,
	output logic instrEnable,
	output rvCorePkg::word_t pc,
	output rvCorePkg::fetchItem_t fetched
);
	import rvCorePkg::*;

	assign instrEnable = fetchAllowed;
	assign instrAddress = fetchAllowed ? pc : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetPc;
		end else if (pcWrite) begin
			// Host sets the counter while halted
			pc <= pcWriteData;
		end else if (advance) begin
			if (redirect) begin
				pc <= redirectTarget;
			end else if (fetchAllowed) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetched.valid <= 1'b0;
		end else if (advance) begin
			// Word behind a taken JAL is wrong-path
			fetched.valid <= fetchAllowed && !redirect;
			fetched.pc <= pc;
			fetched.instruction <= instruction_t'(instrData);
		end
	end

endmodule

// File: source/executeStage.sv
`timescale 1ns/100ps

module executeStage (
	input logic clk,
	input logic rst,
	input logic advance,
	input rvCorePkg::fetchItem_t fetched,
	input rvCorePkg::word_t rs1Data,
	input rvCorePkg::word_t rs2Data,
	output rvCorePkg::regAddr_t rs1Address,
	output rvCorePkg::regAddr_t rs2Address,
	output logic redirect,
	output rvCorePkg::word_t redirectTarget,
	output rvCorePkg::writebackItem_t writeback
);
	import rvCorePkg::*;

	instruction_t instr;
	word_t raw;
	opcode_t opcode;
	word_t immI;
	word_t immU;
	word_t immJ;
	word_t operandB;
	logic [4:0] shamt;
	logic altFunct;
	word_t aluResult;
	word_t result;
	logic supported;

	assign instr = fetched.instruction;
	assign raw = fetched.instruction;
	assign opcode = opcode_t'(instr.r.opcode);
	assign rs1Address = instr.r.rs1;
	assign rs2Address = instr.r.rs2;

	assign immI = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign immU = {raw[31:12], 12'b0};
	assign immJ = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};

	assign operandB = (opcode == opOp) ? rs2Data : immI;
	assign shamt = operandB[4:0];
	// Bit 30 picks SUB and SRA
	assign altFunct = instr.r.funct7[5];

	always_comb begin
		case (instr.r.funct3)
			3'b000: aluResult = (opcode == opOp && altFunct) ? rs1Data - operandB
				: rs1Data + operandB;
			3'b001: aluResult = rs1Data << shamt;
			3'b010: aluResult = word_t'($signed(rs1Data) < $signed(operandB));
			3'b011: aluResult = word_t'(rs1Data < operandB);
			3'b100: aluResult = rs1Data ^ operandB;
			3'b101: aluResult = altFunct ? word_t'($signed(rs1Data) >>> shamt)
				: rs1Data >> shamt;
			3'b110: aluResult = rs1Data | operandB;
			default: aluResult = rs1Data & operandB;
		endcase
	end

	always_comb begin
		supported = 1'b1;
		case (opcode)
			opOp, opImm: result = aluResult;
			opLui: result = immU;
			opAuipc: result = fetched.pc + immU;
			opJal: result = fetched.pc + 32'd4;
			default: begin
				// Unknown opcodes retire as no-ops
				result = '0;
				supported = 1'b0;
			end
		endcase
	end

	assign redirect = fetched.valid && (opcode == opJal);
	assign redirectTarget = fetched.pc + immJ;

	always_ff @(posedge clk) begin
		if (rst) begin
			writeback.valid <= 1'b0;
		end else if (advance) begin
			writeback.valid <= fetched.valid && supported && (instr.r.rd != '0);
			writeback.rd <= instr.r.rd;
			writeback.result <= result;
		end
	end

endmodule

// File: source/registerFile.sv
`timescale 1ns/100ps

module registerFile (
	input logic clk,
	input logic rst,
	input logic advance,
	input rvCorePkg::writebackItem_t writeback,
	input rvCorePkg::regAddr_t rs1Address,
	input rvCorePkg::regAddr_t rs2Address,
	input rvCorePkg::regAddr_t mgmtIndex,
	input logic regWrite,
	input rvCorePkg::word_t mgmtWriteData,
	output rvCorePkg::word_t rs1Data,
	output rvCorePkg::word_t rs2Data,
	output rvCorePkg::word_t mgmtRegData
);
	import rvCorePkg::*;

	word_t registers [32];

	function automatic word_t readOperand(regAddr_t index);
		if (index == '0) begin
			return '0;
		end
		// Pending writeback bypasses the array
		if (writeback.valid && writeback.rd == index) begin
			return writeback.result;
		end
		return registers[index];
	endfunction

	always_comb begin
		rs1Data = readOperand(rs1Address);
		rs2Data = readOperand(rs2Address);
	end

	assign mgmtRegData = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];

	always_ff @(posedge clk) begin
		if (!rst) begin
			if (advance && writeback.valid) begin
				registers[writeback.rd] <= writeback.result;
			end else if (regWrite && mgmtIndex != '0) begin
				registers[mgmtIndex] <= mgmtWriteData;
			end
		end
	end

endmodule

// File: source/managementPort.sv
`timescale 1ns/100ps

module managementPort (
	input logic clk,
	input logic rst,
	input logic run,
	input rvCorePkg::mgmtRequest_t mgmt,
	input logic instrEnable,
	input logic instrBusy,
	input logic pipeActive,
	input rvCorePkg::word_t pc,
	input rvCorePkg::word_t regData,
	output logic running,
	output logic advance,
	output logic fetchAllowed,
	output logic pcWrite,
	output logic regWrite,
	output rvCorePkg::regAddr_t regIndex,
	output rvCorePkg::word_t readData
);
	import rvCorePkg::*;

	typedef enum logic {stateHalt, stateExecute} state_t;

	state_t state;
	mgmtRegion_t region;
	logic selectPc;
	logic selectRegister;
	logic writeValid;
	logic readValid;
	logic pcRead;
	logic regRead;
	word_t selected;

	assign running = (state == stateExecute);
	assign fetchAllowed = running && run;
	// Outstanding fetch freezes every stage
	assign advance = running && !(instrEnable && instrBusy);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
		end else begin
			case (state)
				stateHalt: if (run) state <= stateExecute;
				stateExecute: if (!run && !pipeActive) state <= stateHalt;
			endcase
		end
	end

	assign region = mgmtRegion_t'(mgmt.address[15:14]);
	assign selectPc = (region == regionSystem) && (mgmt.address[13:0] == '0);
	assign selectRegister = (region == regionRegisters) && (mgmt.address[13:7] == '0);
	assign regIndex = mgmt.address[6:2];

	// Host access only while halted
	assign writeValid = !running && mgmt.writeEnable;
	assign readValid = !running && !mgmt.writeEnable;
	assign pcWrite = writeValid && selectPc;
	assign regWrite = writeValid && selectRegister;
	assign pcRead = readValid && selectPc;
	assign regRead = readValid && selectRegister;

	always_comb begin
		if (pcRead) begin
			selected = pc;
		end else if (regRead) begin
			selected = regData;
		end else begin
			selected = '0;
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			readData[8*i +: 8] = mgmt.byteSelect[i] ? selected[8*i +: 8] : 8'h00;
		end
	end

endmodule

// File: source/rvCore.sv
`timescale 1ns/100ps

module rvCore #(
	parameter rvCorePkg::word_t resetPc = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input rvCorePkg::word_t instrData,
	input logic instrBusy,
	input logic run,
	input rvCorePkg::mgmtRequest_t mgmt,
	output rvCorePkg::word_t instrAddress,
	output logic instrEnable,
	output rvCorePkg::word_t mgmtReadData,
	output logic running
);
	import rvCorePkg::*;

	logic advance;
	logic fetchAllowed;
	logic redirect;
	word_t redirectTarget;
	logic pcWrite;
	logic regWrite;
	regAddr_t regIndex;
	word_t pc;
	fetchItem_t fetched;
	writebackItem_t writeback;
	regAddr_t rs1Address;
	regAddr_t rs2Address;
	word_t rs1Data;
	word_t rs2Data;
	word_t regData;
	logic pipeActive;

	// Halt waits until both stage registers are empty
	assign pipeActive = fetched.valid || writeback.valid;

	instructionFetch #(
		.resetPc(resetPc)
	) fetchStage (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.fetchAllowed(fetchAllowed),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.pcWrite(pcWrite),
		.pcWriteData(mgmt.writeData),
		.instrData(instrData),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.pc(pc),
		.fetched(fetched)
	);

	executeStage execStage (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.fetched(fetched),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rs1Address(rs1Address),
		.rs2Address(rs2Address),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.writeback(writeback)
	);

	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.writeback(writeback),
		.rs1Address(rs1Address),
		.rs2Address(rs2Address),
		.mgmtIndex(regIndex),
		.regWrite(regWrite),
		.mgmtWriteData(mgmt.writeData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtRegData(regData)
	);

	managementPort mgmtPort (
		.clk(clk),
		.rst(rst),
		.run(run),
		.mgmt(mgmt),
		.instrEnable(instrEnable),
		.instrBusy(instrBusy),
		.pipeActive(pipeActive),
		.pc(pc),
		.regData(regData),
		.running(running),
		.advance(advance),
		.fetchAllowed(fetchAllowed),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.regIndex(regIndex),
		.readData(mgmtReadData)
	);

endmodule

// File: tests/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

// File: tests/coreModel.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrStep(logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic word_t aluModel(logic [2:0] f3, logic subtract, logic arith,
		word_t a, word_t b);
	case (f3)
		3'b000: return subtract ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return {31'b0, $signed(a) < $signed(b)};
		3'b011: return {31'b0, a < b};
		3'b100: return a ^ b;
		3'b101: return arith ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

// Runs instrMem on modelRegs until a JAL jumps to itself
function automatic word_t runModel(word_t startPc);
	word_t pcNow;
	word_t inst;
	word_t a;
	word_t b;
	word_t res;
	word_t target;
	logic [6:0] opc;
	logic writes;
	pcNow = startPc;
	for (int steps = 0; steps < 1000; steps++) begin
		inst = instrMem[pcNow[7:2]];
		opc = inst[6:0];
		a = modelRegs[inst[19:15]];
		b = (opc == 7'b0110011) ? modelRegs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
		target = pcNow + 32'd4;
		writes = 1'b1;
		res = '0;
		case (opc)
			7'b0110011: res = aluModel(inst[14:12], inst[30], inst[30], a, b);
			7'b0010011: res = aluModel(inst[14:12], 1'b0, inst[30], a, b);
			7'b0110111: res = {inst[31:12], 12'b0};
			7'b0010111: res = pcNow + {inst[31:12], 12'b0};
			7'b1101111: begin
				res = pcNow + 32'd4;
				target = pcNow + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: writes = 1'b0;
		endcase
		if (writes && inst[11:7] != 5'd0) begin
			modelRegs[inst[11:7]] = res;
		end
		if (target == pcNow) begin
			return pcNow;
		end
		pcNow = target;
	end
	return pcNow;
endfunction

`endif

// File: tests/rvCoreTb.sv
`timescale 1ns/100ps

module rvCoreTb;
	import rvCorePkg::*;

	localparam word_t baseAddr = 32'h0000_0040;

	logic clk;
	logic rst;
	word_t instrData;
	logic instrBusy;
	logic run;
	mgmtRequest_t mgmt;
	word_t instrAddress;
	logic instrEnable;
	word_t mgmtReadData;
	logic running;

	word_t instrMem [64];
	word_t modelRegs [32];
	word_t seeds [32];
	logic [31:0] lfsrState;
	int progCount;
	logic busyOn;
	logic busyDense;

	`include "coreModel.svh"

	clockGen clocks (.clk(clk), .rst(rst));

	rvCore #(.resetPc(baseAddr)) uut (
		.clk(clk), .rst(rst), .instrData(instrData), .instrBusy(instrBusy), .run(run),
		.mgmt(mgmt), .instrAddress(instrAddress), .instrEnable(instrEnable),
		.mgmtReadData(mgmtReadData), .running(running)
	);

	assign instrData = instrMem[instrAddress[7:2]];

	function automatic word_t takeBits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Busy level redrawn each cycle during a run
	always begin
		@(posedge clk);
		#2;
		if (!busyOn) begin
			instrBusy = 1'b0;
		end else if (busyDense) begin
			instrBusy = takeBits(1) != 0;
		end else begin
			instrBusy = takeBits(2) == 0;
		end
	end

	function automatic word_t encR(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t encI(int imm, int rs1, int f3, int rd);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic word_t encU(int imm, int rd, logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic word_t encJ(int offset, int rd);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [15:0] regAddress(int i);
		return {2'b01, 7'b0, i[4:0], 2'b00};
	endfunction

	function automatic word_t maskBytes(word_t v, logic [3:0] sel);
		return v & {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	task automatic addInstr(word_t w);
		instrMem[baseAddr[7:2] + progCount] = w;
		progCount++;
	endtask

	task automatic loadProgram();
		// Unused words decode as no-ops
		for (int i = 0; i < 64; i++) begin
			instrMem[i] = word_t'(i) << 7;
		end
		progCount = 0;
		addInstr(encI(-7, 1, 0, 5));
		addInstr(encR(0, 2, 5, 0, 6));
		addInstr(encR(32, 3, 6, 0, 7));
		addInstr(encR(0, 4, 7, 1, 8));
		addInstr(encR(0, 1, 8, 2, 9));
		addInstr(encR(0, 8, 1, 3, 10));
		addInstr(encR(0, 9, 10, 4, 11));
		addInstr(encR(0, 3, 2, 5, 12));
		addInstr(encR(32, 3, 1, 5, 13));
		addInstr(encR(0, 13, 12, 6, 14));
		addInstr(encR(0, 2, 14, 7, 15));
		addInstr(encI(100, 1, 2, 16));
		addInstr(encI(-1, 2, 3, 17));
		addInstr(encI(12'h5a5, 3, 4, 18));
		addInstr(encI(12'h0f0, 18, 6, 19));
		addInstr(encI(-256, 19, 7, 20));
		addInstr(encI(3, 20, 1, 21));
		addInstr(encI(7, 21, 5, 22));
		addInstr(encI(12'h409, 1, 5, 23));
		addInstr(encU(20'habcde, 24, 7'b0110111));
		addInstr(encU(20'h12345, 25, 7'b0010111));
		addInstr(encR(0, 25, 24, 0, 26));
		// Link over one skipped word
		addInstr(encJ(8, 27));
		addInstr(encI(12'h077, 0, 0, 28));
		addInstr(encI(4, 27, 0, 29));
		addInstr(encR(0, 2, 1, 0, 0));
		addInstr(encJ(0, 0));
	endtask

	task automatic stopWithFailure(string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic checkReg(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stopWithFailure("register data mismatch");
		end
	endtask

	task automatic checkPc(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			stopWithFailure("program counter mismatch");
		end
	endtask

	task automatic checkBit(string name, logic actual, logic expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
			stopWithFailure("control level mismatch");
		end
	endtask

	task automatic writeMgmt(logic [15:0] address, word_t data);
		@(posedge clk);
		#2;
		mgmt.writeEnable = 1'b1;
		mgmt.byteSelect = 4'hf;
		mgmt.address = address;
		mgmt.writeData = data;
		@(posedge clk);
		#2;
		mgmt = '0;
	endtask

	task automatic readMgmt(logic [15:0] address, logic [3:0] sel, output word_t data);
		@(posedge clk);
		#2;
		mgmt.writeEnable = 1'b0;
		mgmt.byteSelect = sel;
		mgmt.address = address;
		mgmt.writeData = '0;
		@(negedge clk);
		data = mgmtReadData;
	endtask

	task automatic waitRunning(logic level);
		int count;
		count = 0;
		while (running !== level) begin
			@(negedge clk);
			count++;
			if (count > 2000) begin
				stopWithFailure("running never reached the expected level");
			end
		end
	endtask

	task automatic waitLoopFetch(word_t loopAddr);
		int count;
		count = 0;
		while (!(instrEnable === 1'b1 && instrAddress === loopAddr)) begin
			@(negedge clk);
			count++;
			if (count > 2000) begin
				stopWithFailure("core never fetched the self-loop address");
			end
		end
	endtask

	task automatic runProgram(logic dense);
		writeMgmt(16'h0000, baseAddr);
		@(negedge clk);
		busyDense = dense;
		busyOn = 1'b1;
		@(posedge clk);
		#2;
		run = 1'b1;
		waitRunning(1'b1);
		// Host writes here must be ignored
		writeMgmt(regAddress(31), 32'hdead_beef);
		writeMgmt(16'h0000, baseAddr + 32'd92);
		waitLoopFetch(baseAddr + 32'(4 * (progCount - 1)));
		@(posedge clk);
		#2;
		run = 1'b0;
		waitRunning(1'b0);
		@(negedge clk);
		busyOn = 1'b0;
	endtask

	task automatic checkAll(word_t expectedPc);
		word_t value;
		for (int i = 0; i < 32; i++) begin
			readMgmt(regAddress(i), 4'hf, value);
			checkReg($sformatf("x%0d", i), value, modelRegs[i]);
		end
		readMgmt(16'h0000, 4'hf, value);
		checkPc("pc", value, expectedPc);
	endtask

	initial begin
		word_t value;
		word_t expectedPc;
		int waitCount;
		run = 1'b0;
		mgmt = '0;
		instrBusy = 1'b0;
		busyOn = 1'b0;
		busyDense = 1'b0;
		lfsrState = 32'h889d;
		loadProgram();
		waitCount = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			waitCount++;
			if (waitCount > 20) begin
				stopWithFailure("reset never released");
			end
		end
		checkBit("running", running, 1'b0);
		checkBit("instrEnable", instrEnable, 1'b0);
		readMgmt(16'h0000, 4'hf, value);
		checkPc("pc", value, baseAddr);
		readMgmt(regAddress(0), 4'hf, value);
		checkReg("x0", value, '0);

		seeds[0] = '0;
		for (int i = 1; i < 32; i++) begin
			seeds[i] = takeBits(32);
			writeMgmt(regAddress(i), seeds[i]);
		end
		for (int i = 1; i < 32; i++) begin
			readMgmt(regAddress(i), 4'hf, value);
			checkReg($sformatf("x%0d", i), value, seeds[i]);
			expectedPc = takeBits(4);
			readMgmt(regAddress(i), expectedPc[3:0], value);
			checkReg($sformatf("x%0d masked", i), value, maskBytes(seeds[i], expectedPc[3:0]));
		end

		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = seeds[i];
		end
		expectedPc = runModel(baseAddr);
		runProgram(1'b0);
		checkAll(expectedPc);
		readMgmt(regAddress(27), 4'hf, value);
		checkReg("x27 link", value, baseAddr + 32'd92);
		readMgmt(regAddress(28), 4'hf, value);
		checkReg("x28 skipped", value, seeds[28]);
		readMgmt(regAddress(31), 4'hf, value);
		checkReg("x31 untouched", value, seeds[31]);

		// Same program again with a denser busy pattern
		expectedPc = runModel(baseAddr);
		runProgram(1'b1);
		checkAll(expectedPc);
		readMgmt(16'h0000, 4'hf, value);
		checkPc("self-loop pc", value, baseAddr + 32'(4 * (progCount - 1)));

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: project.f
+incdir+tests
source/rvCorePkg.sv
source/instructionFetch.sv
source/executeStage.sv
source/registerFile.sv
source/managementPort.sv
source/rvCore.sv
tests/clockGen.sv
tests/rvCoreTb.sv

// File: build.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module rvCoreTb -o rvCoreSim
./obj_dir/rvCoreSim > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
